//--- common/fetch_pkg.sv
//######################################################################
// Shared widths, cache geometry, AXI codes and packed structs for the
// instruction fetch stage
//######################################################################
package fetch_pkg;

    localparam int ADDR_W      = 16;  // PC and byte address width
    localparam int INSTR_W     = 16;  // One instruction
    localparam int AXI_DATA_W  = 32;  // Two instructions per beat
    localparam int LINE_BYTES  = 8;   // Four instructions per line
    localparam int NUM_LINES   = 16;

    // Derived cache geometry
    localparam int OFFSET_W    = $clog2(LINE_BYTES);              // 3
    localparam int INDEX_W     = $clog2(NUM_LINES);               // 4
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;     // 9
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;               // 13
    localparam int LINE_W      = LINE_BYTES * 8;                  // 64
    localparam int HALF_W      = OFFSET_W - 1;                    // Halfword select
    localparam int BYTE_OFF_W  = $clog2(AXI_DATA_W / 8);          // Byte lane bits
    localparam int NUM_BEATS   = LINE_W / AXI_DATA_W;             // Beats per line
    localparam int BEAT_W      = $clog2(NUM_BEATS);

    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // AXI response codes and AR protection
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [2:0] PROT_INSTR  = 3'b100;  // Instruction, secure, unprivileged

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } cpu_req_t;

    typedef struct packed {
        logic               ready;
        logic [INSTR_W-1:0] instr;
        logic               err;
    } cpu_res_t;

    typedef struct packed {
        logic                   valid;
        logic [LINE_ADDR_W-1:0] addr;
    } line_req_t;

    typedef struct packed {
        logic              done;
        logic [LINE_W-1:0] line;
        logic              err;
    } line_res_t;

    typedef struct packed {
        logic               valid;
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
        logic               err;
    } fetch_out_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
    } axi_r_t;

endpackage

//--- logic/redirect_capture.sv
`timescale 1ns/10ps
//######################################################################
// Two-stage branch target hold between the redirect pulse and the PC
//######################################################################
module redirect_capture import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_PC_src,
    input  redirect_t redirect,   // One-cycle pulse from outside
    input  logic      commit,     // Fetch unit can take a new address
    input  logic      clear,      // Committed target was loaded
    output redirect_t committed
);

    logic              pend_vld_q;
    logic [ADDR_W-1:0] pend_tgt_q;
    logic              cmt_vld_q;
    logic [ADDR_W-1:0] cmt_tgt_q;

    // First stage holds the pulse until commit
    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            pend_vld_q <= 1'b0;
        end else if (redirect.valid) begin
            pend_vld_q <= 1'b1;       // Newer pulse wins over commit
        end else if (commit) begin
            pend_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.valid) pend_tgt_q <= redirect.target;
    end

    // Second stage presents the target until the PC has taken it
    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            cmt_vld_q <= 1'b0;
        end else if (commit && pend_vld_q) begin
            cmt_vld_q <= 1'b1;
        end else if (clear) begin
            cmt_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit && pend_vld_q) cmt_tgt_q <= pend_tgt_q;
    end

    assign committed = '{valid: cmt_vld_q, target: cmt_tgt_q};

endmodule

//--- fetch/if_unit.sv
`timescale 1ns/10ps
//######################################################################
// Fetch unit with the program counter, redirect load and the output
// register toward decode
//######################################################################
module if_unit import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_PC_src,
    input  redirect_t  committed,   // Target ready to load into the PC
    input  cpu_res_t   cpu_res,
    input  logic       out_ready,   // Decode stall when low
    output logic       commit,
    output logic       clear,
    output cpu_req_t   cpu_req,
    output fetch_out_t fetch_out
);

    logic [ADDR_W-1:0]  pc_q;
    logic               req_vld_q;    // Low only in the first cycle after reset
    logic               out_vld_q;
    logic [ADDR_W-1:0]  out_pc_q;
    logic [INSTR_W-1:0] out_instr_q;
    logic               out_err_q;
    logic               out_free;     // Output register empty or being drained
    logic               take;         // Cache word moves into the output register

    assign out_free = !out_vld_q || out_ready;

    // A committed redirect discards the word looked up for the old PC
    assign take = cpu_res.ready && out_free && !committed.valid;

    // Redirect may move on when a lookup completes or before the first request
    assign commit = cpu_res.ready || !req_vld_q;
    assign clear  = committed.valid;   // PC loads the target this cycle

    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            req_vld_q <= 1'b0;
        end else begin
            req_vld_q <= 1'b1;
        end
    end

    // Program counter
    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            pc_q <= RESET_PC;
        end else if (committed.valid) begin
            pc_q <= committed.target;                  // Branch target
        end else if (take) begin
            pc_q <= pc_q + ADDR_W'(INSTR_W / 8);       // Next halfword
        end
    end

    // Cache address is the PC itself and stays put until ready
    assign cpu_req = '{valid: req_vld_q, addr: pc_q};

    // Output valid toward decode
    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            out_vld_q <= 1'b0;
        end else if (take) begin
            out_vld_q <= 1'b1;
        end else if (out_ready) begin
            out_vld_q <= 1'b0;   // Accepted and nothing new behind it
        end
    end

    // Payload only changes on a new word so it holds while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            out_pc_q    <= pc_q;
            out_instr_q <= cpu_res.instr;
            out_err_q   <= cpu_res.err;
        end
    end

    assign fetch_out = '{
        valid: out_vld_q,
        pc:    out_pc_q,
        instr: out_instr_q,
        err:   out_err_q
    };

endmodule

//--- icache/icache_store.sv
`timescale 1ns/10ps
//######################################################################
// Cache tag, valid and data arrays with registered read
//######################################################################
module icache_store import fetch_pkg::*; (
    input  logic               clk,
    input  logic               rst_PC_src,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic               wr_en,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [TAG_W-1:0]   wr_tag,
    input  logic [LINE_W-1:0]  wr_line,
    output logic [TAG_W-1:0]   rd_tag,
    output logic               rd_valid,
    output logic [LINE_W-1:0]  rd_line
);

    logic [TAG_W-1:0]  tag_mem  [NUM_LINES];
    logic [LINE_W-1:0] data_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;   // One bit per line

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_line;
        end
        rd_tag  <= tag_mem[rd_index];    // Old contents on a same-index write
        rd_line <= data_mem[rd_index];
    end

    // Valid bits start cleared
    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid_q[rd_index];
        end
    end

endmodule

//--- icache/icache_ctrl.sv
`timescale 1ns/10ps
//######################################################################
// Direct-mapped instruction cache controller with lookup, refill and
// respond states
//######################################################################
module icache_ctrl import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_PC_src,
    input  cpu_req_t  cpu_req,
    input  line_res_t line_res,
    output cpu_res_t  cpu_res,
    output line_req_t line_req
);

    typedef enum logic [1:0] {ST_LOOKUP, ST_REFILL, ST_RESPOND} state_t;

    state_t            state_q;
    state_t            state_d;
    logic [ADDR_W-1:0] look_addr_q;   // Address behind the store read data
    logic              look_vld_q;
    logic [ADDR_W-1:0] miss_addr_q;   // Address being refilled
    logic [LINE_W-1:0] fill_line_q;
    logic              fill_err_q;
    logic [TAG_W-1:0]  rd_tag;
    logic              rd_valid;
    logic [LINE_W-1:0] rd_line;
    logic              look_match;
    logic              hit;
    logic              miss;
    logic              resp_match;
    logic              wr_en;

    function automatic logic [INSTR_W-1:0] pick_half(input logic [LINE_W-1:0] line,
                                                     input logic [HALF_W-1:0] sel);
        return line[sel*INSTR_W +: INSTR_W];   // Low halfword is the lower address
    endfunction

    // Store read data only counts when it belongs to the current request
    assign look_match = look_vld_q && cpu_req.valid && (look_addr_q == cpu_req.addr);
    assign hit  = look_match && rd_valid && (rd_tag == look_addr_q[ADDR_W-1 -: TAG_W]);
    assign miss = look_match && !hit && (state_q == ST_LOOKUP);
    assign resp_match = cpu_req.valid && (cpu_req.addr == miss_addr_q);
    assign wr_en = (state_q == ST_REFILL) && line_res.done && !line_res.err;   // Good fill only

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP:  if (miss) state_d = ST_REFILL;
            ST_REFILL:  if (line_res.done) state_d = ST_RESPOND;
            ST_RESPOND: if (!resp_match) state_d = ST_LOOKUP;   // PC has moved on
            default:    state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            state_q    <= ST_LOOKUP;
            look_vld_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            look_vld_q <= cpu_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        look_addr_q <= cpu_req.addr;               // Tracks the registered read
        if (miss) miss_addr_q <= look_addr_q;
        if ((state_q == ST_REFILL) && line_res.done) begin
            fill_line_q <= line_res.line;
            fill_err_q  <= line_res.err;
        end
    end

    always_comb begin
        cpu_res = '{ready: 1'b0, instr: pick_half(rd_line, look_addr_q[1 +: HALF_W]),
                    err: 1'b0};
        case (state_q)
            ST_LOOKUP: cpu_res.ready = hit;
            ST_RESPOND: begin
                cpu_res.ready = resp_match;
                cpu_res.err   = fill_err_q;
                cpu_res.instr = fill_err_q ? '0 : pick_half(fill_line_q, miss_addr_q[1 +: HALF_W]);
            end
            default: cpu_res.ready = 1'b0;   // Refill in progress
        endcase
    end

    assign line_req = '{valid: (state_q == ST_REFILL),
                        addr:  miss_addr_q[ADDR_W-1:OFFSET_W]};

    icache_store u_store (
        .clk        (clk),
        .rst_PC_src (rst_PC_src),
        .rd_index   (cpu_req.addr[OFFSET_W +: INDEX_W]),
        .wr_en      (wr_en),
        .wr_index   (miss_addr_q[OFFSET_W +: INDEX_W]),
        .wr_tag     (miss_addr_q[ADDR_W-1 -: TAG_W]),
        .wr_line    (line_res.line),
        .rd_tag     (rd_tag),
        .rd_valid   (rd_valid),
        .rd_line    (rd_line)
    );

endmodule

//--- logic/axi_rd_master.sv
`timescale 1ns/10ps
//######################################################################
// AXI4-Lite read master fetching one cache line as sequential beats
//######################################################################
module axi_rd_master import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_PC_src,
    input  line_req_t line_req,
    input  logic      ar_ready,
    input  axi_r_t    r,
    output line_res_t line_res,
    output axi_ar_t   ar,
    output logic      r_ready
);

    typedef enum logic [1:0] {ST_IDLE, ST_AR, ST_R, ST_DONE} state_t;

    state_t                 state_q;
    logic [BEAT_W-1:0]      beat_q;       // Beat within the line
    logic [LINE_ADDR_W-1:0] line_addr_q;
    logic [LINE_W-1:0]      line_q;       // Assembled line
    logic                   err_q;
    logic                   last_beat;

    assign last_beat = (beat_q == BEAT_W'(NUM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst_PC_src) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (line_req.valid) begin
                    state_q <= ST_AR;
                    beat_q  <= '0;
                end
                ST_AR: if (ar_ready) state_q <= ST_R;   // Address accepted
                ST_R: if (r.valid) begin
                    if (last_beat) begin
                        state_q <= ST_DONE;
                    end else begin
                        state_q <= ST_AR;               // Next AR after this beat
                        beat_q  <= beat_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;            // Done lasts one cycle
            endcase
        end
    end

    // Line data and response collection
    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && line_req.valid) begin
            line_addr_q <= line_req.addr;
            err_q       <= 1'b0;
        end
        if ((state_q == ST_R) && r.valid) begin
            line_q[beat_q*AXI_DATA_W +: AXI_DATA_W] <= r.data;
            err_q <= err_q | (r.resp != RESP_OKAY);   // Any bad beat fails the line
        end
    end

    assign ar = '{
        valid: (state_q == ST_AR),
        addr:  {line_addr_q, beat_q, {BYTE_OFF_W{1'b0}}},
        prot:  PROT_INSTR
    };
    assign r_ready = (state_q == ST_R);

    assign line_res = '{done: (state_q == ST_DONE), line: line_q, err: err_q};

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/10ps
//######################################################################
// Fetch stage top with redirect capture, fetch unit, cache and AXI master
//######################################################################
module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_PC_src,
    input  redirect_t  redirect,
    input  logic       out_ready,
    input  logic       ar_ready,
    input  axi_r_t     r,
    output fetch_out_t fetch_out,
    output axi_ar_t    ar,
    output logic       r_ready
);

    redirect_t committed;
    logic      commit;
    logic      clear;
    cpu_req_t  cpu_req;
    cpu_res_t  cpu_res;
    line_req_t line_req;
    line_res_t line_res;

    redirect_capture u_redirect (
        .clk        (clk),
        .rst_PC_src (rst_PC_src),
        .redirect   (redirect),
        .commit     (commit),
        .clear      (clear),
        .committed  (committed)
    );

    if_unit u_if (
        .clk        (clk),
        .rst_PC_src (rst_PC_src),
        .committed  (committed),
        .cpu_res    (cpu_res),
        .out_ready  (out_ready),
        .commit     (commit),
        .clear      (clear),
        .cpu_req    (cpu_req),
        .fetch_out  (fetch_out)
    );

    icache_ctrl u_icache (
        .clk        (clk),
        .rst_PC_src (rst_PC_src),
        .cpu_req    (cpu_req),
        .line_res   (line_res),
        .cpu_res    (cpu_res),
        .line_req   (line_req)
    );

    // Line refills go out over AXI4-Lite reads
    axi_rd_master u_axi (
        .clk        (clk),
        .rst_PC_src (rst_PC_src),
        .line_req   (line_req),
        .ar_ready   (ar_ready),
        .r          (r),
        .line_res   (line_res),
        .ar         (ar),
        .r_ready    (r_ready)
    );

endmodule

//--- bench/fetch_asserts.sv
`timescale 1ns/10ps
//######################################################################
// Handshake assertions on the AXI read and decode ports, bound into
// the fetch top
//######################################################################
module fetch_asserts import fetch_pkg::*; (
    input logic       clk,
    input logic       rst_PC_src,
    input axi_ar_t    ar,
    input logic       ar_ready,
    input logic       r_ready,
    input fetch_out_t fetch_out,
    input logic       out_ready
);

    int unsigned fail_count = 0;   // Failed assertion count

    // ARVALID holds with the same address until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst_PC_src)
        ar.valid && !ar_ready |=> ar.valid && $stable(ar.addr))
        else begin
            fail_count = fail_count + 1;
            $error("ARVALID dropped or ARADDR changed before ar_ready");
        end

    // Decode payload frozen while stalled
    out_hold: assert property (@(posedge clk) disable iff (rst_PC_src)
        fetch_out.valid && !out_ready |=> $stable(fetch_out))
        else begin
            fail_count = fail_count + 1;
            $error("fetch_out changed while valid and not ready");
        end

    // AXI read side quiet right after reset
    rst_quiet: assert property (@(posedge clk)
        rst_PC_src |=> !ar.valid && !r_ready)
        else begin
            fail_count = fail_count + 1;
            $error("ARVALID or r_ready high in the cycle after reset");
        end

endmodule

bind fetch_top fetch_asserts u_asserts (
    .clk        (clk),
    .rst_PC_src (rst_PC_src),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r_ready    (r_ready),
    .fetch_out  (fetch_out),
    .out_ready  (out_ready)
);

//--- bench/tb_fetch.sv
`timescale 1ns/10ps
//######################################################################
// Fetch stage testbench with an AXI4-Lite memory model and directed tests
//######################################################################
module tb_fetch import fetch_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;   // All tests at worst-case miss latency, with margin

    logic        clk;
    logic        rst_PC_src;
    redirect_t   redirect;
    logic        out_ready;
    logic        ar_ready = 1'b0;
    axi_r_t      r = '0;
    fetch_out_t  fetch_out;
    axi_ar_t     ar;
    logic        r_ready;

    int unsigned seed_val;
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned cycles = 0;
    int unsigned ar_count = 0;       // AR handshakes seen by the model
    int unsigned err_ar_count = 0;   // Those inside the error region
    int unsigned ar_wait = 0;
    int unsigned r_wait = 0;
    logic        r_pend = 1'b0;      // Beat owed on R
    logic [15:0] r_addr = '0;

    fetch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory rule: halfword index xor A5C3
    function automatic logic [15:0] mem_half(input logic [15:0] a);
        return (a >> 1) ^ 16'hA5C3;
    endfunction

    function automatic logic in_err_region(input logic [15:0] a);
        return (a >= 16'h0800) && (a <= 16'h0807);
    endfunction

    // AXI4-Lite slave, random 0 to 3 cycle ready delays
    always @(posedge clk) begin
        if (rst_PC_src) begin
            ar_ready <= 1'b0;
            r        <= '0;
            r_pend   <= 1'b0;
        end else begin
            if (ar.valid && ar_ready) begin                // AR handshake
                ar_ready <= 1'b0;
                ar_count <= ar_count + 1;
                compare("ar.prot[2]", 64'(ar.prot[2]), 64'h1);   // Instruction access
                if (in_err_region(ar.addr)) err_ar_count <= err_ar_count + 1;
                r_addr  <= ar.addr;
                r_pend  <= 1'b1;
                r_wait  <= $urandom % 4;
                ar_wait <= $urandom % 4;
            end else if (ar.valid) begin
                if (ar_wait == 0) ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (r.valid && r_ready) begin
                r <= '0;                                   // Beat taken
            end else if (r_pend && !r.valid) begin
                if (r_wait == 0) begin
                    r <= '{valid: 1'b1,
                           data:  {mem_half(r_addr + 16'd2), mem_half(r_addr)},
                           resp:  in_err_region(r_addr) ? RESP_SLVERR : RESP_OKAY};
                    r_pend <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Error: %s at %0t", msg, $time);
    endtask

    task automatic report_test(input string name, input int unsigned err_before);
        $display("%-24s done, %0d errors", name, errors - err_before);
    endtask

    // One decode handshake after wait_cyc stalled cycles, payload watched meanwhile
    task automatic get_word(input int unsigned wait_cyc, output fetch_out_t w);
        fetch_out_t  held;
        logic        seen;
        logic        got;
        int unsigned n;
        held = '0;
        seen = 1'b0;
        got  = 1'b0;
        n    = 0;
        while (!got) begin
            @(posedge clk);
            if (fetch_out.valid && out_ready) begin
                w = fetch_out;
                out_ready <= 1'b0;
                got = 1'b1;
            end else begin
                if (seen) compare("fetch_out while stalled", 64'(fetch_out), 64'(held));
                seen = fetch_out.valid;
                held = fetch_out;
                if (n >= wait_cyc) out_ready <= 1'b1;
                n++;
            end
        end
    endtask

    task automatic check_word(input fetch_out_t w, input logic [15:0] pc);
        logic err;
        err = in_err_region(pc);                           // Bad fill gives zero instr
        compare("fetch_out.pc", 64'(w.pc), 64'(pc));
        compare("fetch_out.instr", 64'(w.instr), err ? 64'h0 : 64'(mem_half(pc)));
        compare("fetch_out.err", 64'(w.err), 64'(err));
    endtask

    task automatic check_run(input logic [15:0] first, input int count,
                             input int unsigned max_wait);
        fetch_out_t w;
        for (int i = 0; i < count; i++) begin
            get_word($urandom % (max_wait + 1), w);
            check_word(w, first + 16'(2 * i));
        end
    endtask

    // Pulse a redirect and drop wrong-path words up to the target
    task automatic redirect_to(input logic [15:0] target, output fetch_out_t w);
        int n;
        @(posedge clk);
        redirect <= '{valid: 1'b1, target: target};
        @(posedge clk);
        redirect <= '0;
        n = 0;
        get_word(0, w);
        while (w.pc != target && n < 8) begin
            n++;
            get_word(0, w);
        end
        if (w.pc != target) note_failure($sformatf("redirect to %h never reached decode", target));
    endtask

    task automatic sequential_fetch();
        int unsigned e0;
        e0 = errors;
        check_run(16'h0000, 12, 0);
        report_test("sequential fetch", e0);
    endtask

    task automatic redirect_jump();
        fetch_out_t  w;
        int unsigned e0;
        e0 = errors;
        redirect_to(16'h0040, w);
        check_word(w, 16'h0040);
        check_run(16'h0042, 5, 0);
        report_test("redirect jump", e0);
    endtask

    task automatic cached_loop();
        fetch_out_t  w;
        int unsigned e0;
        int unsigned c0;
        e0 = errors;
        c0 = ar_count;
        for (int k = 0; k < 3; k++) begin                  // Lines 1 and 2 already filled
            redirect_to(16'h0008, w);
            check_word(w, 16'h0008);
            check_run(16'h000A, 3, 0);
        end
        compare("ar handshakes in loop", 64'(ar_count - c0), 64'h0);
        report_test("cached loop", e0);
    endtask

    task automatic decode_stall();
        fetch_out_t  w;
        int unsigned e0;
        e0 = errors;
        redirect_to(16'h0100, w);
        check_word(w, 16'h0100);
        check_run(16'h0102, 20, 4);
        report_test("decode stall", e0);
    endtask

    task automatic error_region();
        fetch_out_t  w;
        int unsigned e0;
        int unsigned c0;
        e0 = errors;
        redirect_to(16'h0800, w);
        check_word(w, 16'h0800);
        redirect_to(16'h0200, w);                          // Away, so the refetch is clean
        check_word(w, 16'h0200);
        c0 = err_ar_count;
        redirect_to(16'h0800, w);
        check_word(w, 16'h0800);
        if (err_ar_count - c0 < 2) note_failure("error line was not read again over AXI");
        report_test("error region", e0);
    endtask

    task automatic index_conflict();
        fetch_out_t  w;
        logic [15:0] tgt;
        int unsigned e0;
        int unsigned c0;
        e0 = errors;
        redirect_to(16'h0300, w);                          // Index 0, tag 6
        check_word(w, 16'h0300);
        for (int k = 0; k < 4; k++) begin
            c0  = ar_count;
            tgt = (k % 2 == 0) ? 16'h0380 : 16'h0300;      // Same index, other tag
            redirect_to(tgt, w);
            check_word(w, tgt);
            compare("ar handshakes per switch", 64'(ar_count - c0), 64'h2);
        end
        report_test("index conflict", e0);
    endtask

    initial begin
        seed_val   = $urandom(30);
        rst_PC_src = 1'b1;
        redirect   = '0;
        out_ready  = 1'b0;
        repeat (4) @(posedge clk);
        rst_PC_src <= 1'b0;
        sequential_fetch();
        redirect_jump();
        cached_loop();
        decode_stall();
        error_region();
        index_conflict();
        compare("assertion failures", 64'(UUT.u_asserts.fail_count), 64'h0);
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
common/fetch_pkg.sv
logic/redirect_capture.sv
fetch/if_unit.sv
icache/icache_store.sv
icache/icache_ctrl.sv
logic/axi_rd_master.sv
logic/fetch_top.sv
bench/fetch_asserts.sv
bench/tb_fetch.sv

//--- Makefile
# Verilator lint, simulation and cleanup for the fetch stage testbench
TOP = tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
